//--- include/bp_consts.svh
// table geometry for the branch predictor; the index and tag slices must cover pc bits 31:2 exactly
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// index into both the pht and the btb
`define BP_INDEX_BITS 11              // pc bits 12:2
`define BP_ENTRIES    2048            // must equal 2**BP_INDEX_BITS

// pc slice positions
`define BP_INDEX_LSB  2               // word aligned fetch so bits 1:0 are dropped
`define BP_TAG_BITS   19              // pc bits 31:13 sit above the index

// datapath width
`define BP_PC_BITS    32

`endif // BP_CONSTS_SVH

//--- rtl/bp_pkg.sv
// shared types for the branch predictor; widths come from bp_consts.svh so include it first
`default_nettype none

`include "bp_consts.svh"

package bp_pkg;

    // 2-bit saturating direction counter
    // the two upper encodings predict taken
    typedef enum logic [1:0] {
        STRONG_NOT_TAKEN = 2'b00,
        WEAK_NOT_TAKEN   = 2'b01,
        WEAK_TAKEN       = 2'b10,
        STRONG_TAKEN     = 2'b11
    } pht_state_e;

    // kind of control transfer that the memory stage resolved
    typedef enum logic [1:0] {
        BR_NONE = 2'b00,                  // not a branch so no table changes
        BR_BEQ  = 2'b01,
        BR_BNE  = 2'b10,
        BR_JAL  = 2'b11                   // always resolves taken
    } br_op_e;

    // answer to fetch in the same cycle
    typedef struct packed {
        logic                    taken;   // redirect fetch
        logic [`BP_PC_BITS-1:0]  target;  // zero when not taken
    } bp_pred_t;

    // one resolved branch from the memory stage
    typedef struct packed {
        logic [`BP_PC_BITS-1:0]  pc;      // address of the branch itself
        br_op_e                  op;
        logic                    taken;   // actual outcome
        logic [`BP_PC_BITS-1:0]  target;  // actual destination if taken
    } bp_update_t;

endpackage

`default_nettype wire

//--- rtl/pattern_history_table.sv
// direction table of saturating counters; one write per cycle at most and no read-during-write bypass
`default_nettype none

`include "bp_consts.svh"

module pattern_history_table
    import bp_pkg::*;
(
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic [`BP_PC_BITS-1:0] rd_pc,       // fetch pc
    output logic                   pred_taken,
    input  logic                   wr_en,       // single cycle strobe from the update ctrl
    input  bp_update_t             wr
);

    pht_state_e              cnt [`BP_ENTRIES];   // one counter per index

    logic [`BP_INDEX_BITS-1:0] rd_idx;
    logic [`BP_INDEX_BITS-1:0] wr_idx;
    pht_state_e              rd_state;
    pht_state_e              cur_state;           // counter being trained
    pht_state_e              nxt_state;
    logic                    do_wr;

    // lookup side
    assign rd_idx     = rd_pc[`BP_INDEX_LSB +: `BP_INDEX_BITS];
    assign rd_state   = cnt[rd_idx];
    assign pred_taken = (rd_state == WEAK_TAKEN) || (rd_state == STRONG_TAKEN);

    // update side
    assign wr_idx    = wr.pc[`BP_INDEX_LSB +: `BP_INDEX_BITS];
    assign cur_state = cnt[wr_idx];
    assign do_wr     = wr_en && (wr.op != BR_NONE);   // non-branches leave counters alone

    // one step toward the resolved outcome, pinned at both ends
    always_comb begin
        case (cur_state)
            STRONG_NOT_TAKEN: nxt_state = wr.taken ? WEAK_NOT_TAKEN : STRONG_NOT_TAKEN;
            WEAK_NOT_TAKEN:   nxt_state = wr.taken ? WEAK_TAKEN     : STRONG_NOT_TAKEN;
            WEAK_TAKEN:       nxt_state = wr.taken ? STRONG_TAKEN   : WEAK_NOT_TAKEN;
            STRONG_TAKEN:     nxt_state = wr.taken ? STRONG_TAKEN   : WEAK_TAKEN;
            default:          nxt_state = WEAK_NOT_TAKEN;     // unknown counter falls back to weak
        endcase
    end

    // counters start weak so a single taken outcome flips them
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `BP_ENTRIES; i++) begin
                cnt[i] <= WEAK_NOT_TAKEN;
            end
        end else if (do_wr) begin
            cnt[wr_idx] <= nxt_state;
        end
    end

    // the controller pulses the strobe for one cycle per request
    // a held strobe would train the same counter twice from one branch
    a_wr_en_single: assert property (
        @(posedge CLK) disable iff (!nRST)
        wr_en |=> !wr_en
    ) else $error("pht write strobe held for two cycles");

endmodule

`default_nettype wire

//--- rtl/branch_target_buffer.sv
// direct mapped target buffer; only taken branches allocate and a newer branch evicts an older one
`default_nettype none

`include "bp_consts.svh"

module branch_target_buffer
    import bp_pkg::*;
(
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic [`BP_PC_BITS-1:0] rd_pc,       // fetch pc
    output logic                   hit,
    output logic [`BP_PC_BITS-1:0] hit_target,
    input  logic                   wr_en,
    input  bp_update_t             wr
);

    localparam int TAG_LSB = `BP_INDEX_LSB + `BP_INDEX_BITS;   // first pc bit above the index

    logic                    valid   [`BP_ENTRIES];
    logic [`BP_TAG_BITS-1:0] tag_mem [`BP_ENTRIES];
    logic [`BP_PC_BITS-1:0]  tgt_mem [`BP_ENTRIES];

    logic [`BP_INDEX_BITS-1:0] rd_idx;
    logic [`BP_TAG_BITS-1:0]   rd_tag;
    logic [`BP_INDEX_BITS-1:0] wr_idx;
    logic [`BP_TAG_BITS-1:0]   wr_tag;
    logic                      do_wr;

    // lookup side
    assign rd_idx = rd_pc[`BP_INDEX_LSB +: `BP_INDEX_BITS];
    assign rd_tag = rd_pc[TAG_LSB +: `BP_TAG_BITS];

    // a pc that only aliases in the index misses on the tag
    assign hit        = valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign hit_target = tgt_mem[rd_idx];        // meaningful only with hit

    // update side
    assign wr_idx = wr.pc[`BP_INDEX_LSB +: `BP_INDEX_BITS];
    assign wr_tag = wr.pc[TAG_LSB +: `BP_TAG_BITS];

    // not-taken outcomes and non-branches keep the entry as it is
    assign do_wr = wr_en && wr.taken && (wr.op != BR_NONE);

    // valid bits start clear
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `BP_ENTRIES; i++) begin
                valid[i] <= 1'b0;
            end
        end else if (do_wr) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    // tag and target arrays
    // an entry is read only once its valid bit is set
    always_ff @(posedge CLK) begin
        if (do_wr) begin
            tag_mem[wr_idx] <= wr_tag;      // replaces any earlier owner
            tgt_mem[wr_idx] <= wr.target;
        end
    end

    // a valid bit is set together with its target so a hit never exposes stale X data
    // covers the whole path from the update ctrl capture through this write
    a_hit_target_known: assert property (
        @(posedge CLK) disable iff (!nRST)
        hit |-> !$isunknown(hit_target)
    ) else $error("btb hit with unknown target at pc %h", rd_pc);

endmodule

`default_nettype wire

//--- rtl/bp_update_ctrl.sv
// four-phase receiver for resolved branches; requester must hold upd stable until upd_ack is high
`default_nettype none

`include "bp_consts.svh"

module bp_update_ctrl
    import bp_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,
    input  logic       upd_req,     // from the memory stage
    input  bp_update_t upd,
    output logic       upd_ack,
    output logic       wr_en,       // one cycle per accepted request
    output bp_update_t wr           // held copy of upd for both tables
);

    typedef enum logic [1:0] {
        IDLE  = 2'b00,              // waiting for req
        WRITE = 2'b01,              // drive the table strobe
        ACK   = 2'b10               // hold ack until req drops
    } upd_state_e;

    upd_state_e state;

    // control path
    // edge 0 samples req and captures
    // edge 1 raises wr_en
    // edge 2 lowers wr_en and raises ack with the tables written
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state   <= IDLE;
            wr_en   <= 1'b0;
            upd_ack <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (upd_req) begin
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    wr_en <= 1'b1;
                    state <= ACK;
                end
                ACK: begin
                    wr_en <= 1'b0;
                    if (wr_en) begin
                        upd_ack <= 1'b1;        // write lands on this edge
                    end else if (!upd_req) begin
                        upd_ack <= 1'b0;        // phase 3 of the handshake
                        state   <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // payload capture
    // later changes on upd are ignored until the handshake closes
    always_ff @(posedge CLK) begin
        if ((state == IDLE) && upd_req) begin
            wr <= upd;
        end
    end

    // ack only answers a live request
    a_ack_needs_req: assert property (
        @(posedge CLK) disable iff (!nRST)
        $rose(upd_ack) |-> $past(upd_req)
    ) else $error("upd_ack rose without a pending upd_req");

    // tables are written before the requester is released
    a_ack_after_write: assert property (
        @(posedge CLK) disable iff (!nRST)
        wr_en |=> upd_ack
    ) else $error("upd_ack did not follow the table write");

endmodule

`default_nettype wire

//--- rtl/branch_predictor.sv
// fetch-side predictor; lookup is combinational with no handshake and updates use four-phase req/ack
`default_nettype none

`include "bp_consts.svh"

module branch_predictor
    import bp_pkg::*;
(
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic [`BP_PC_BITS-1:0] fetch_pc,    // answered in the same cycle
    output bp_pred_t               pred,
    input  logic                   upd_req,     // resolved branch from mem stage
    input  bp_update_t             upd,
    output logic                   upd_ack
);

    logic                   pred_taken;     // direction from the counters
    logic                   hit;            // btb owns this pc
    logic [`BP_PC_BITS-1:0] hit_target;
    logic                   wr_en;          // shared strobe to both tables
    bp_update_t             wr;
    logic                   redirect;

    // handshake and write sequencing
    bp_update_ctrl u_bp_update_ctrl (
        .CLK     (CLK),
        .nRST    (nRST),
        .upd_req (upd_req),
        .upd     (upd),
        .upd_ack (upd_ack),
        .wr_en   (wr_en),
        .wr      (wr)
    );

    // direction
    pattern_history_table u_pattern_history_table (
        .CLK        (CLK),
        .nRST       (nRST),
        .rd_pc      (fetch_pc),
        .pred_taken (pred_taken),
        .wr_en      (wr_en),
        .wr         (wr)
    );

    // target
    branch_target_buffer u_branch_target_buffer (
        .CLK        (CLK),
        .nRST       (nRST),
        .rd_pc      (fetch_pc),
        .hit        (hit),
        .hit_target (hit_target),
        .wr_en      (wr_en),
        .wr         (wr)
    );

    // taken needs both a taken counter and a known target
    assign redirect = pred_taken && hit;

    // target forced to zero so fetch never sees a stale entry
    assign pred.taken  = redirect;
    assign pred.target = redirect ? hit_target : '0;

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
// free running 8 ns clock; nRST is held low for 5 rising edges and releases 1 ns after the fifth
`default_nettype none

module tb_clock_gen (
    output logic CLK,
    output logic nRST
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;          // 8 ns period
    end

    initial begin
        nRST = 1'b0;                    // asserted from time zero
        repeat (5) @(posedge CLK);
        #1;
        nRST = 1'b1;                    // released off the edge like the other stimulus
    end

endmodule

`default_nettype wire

//--- verif/tb_branch_predictor.sv
// self-checking testbench; pred is compared with a table model at every edge where fetch_pc held
`default_nettype none

`include "bp_consts.svh"

module tb_branch_predictor
    import bp_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HS_TIMEOUT     = 50;     // cycles allowed per handshake wait
    localparam int RESET_TIMEOUT  = 20;
    localparam int RANDOM_UPDATES = 300;

    logic                   CLK;
    logic                   nRST;
    logic [`BP_PC_BITS-1:0] fetch_pc;
    bp_pred_t               pred;
    logic                   upd_req;
    bp_update_t             upd;
    logic                   upd_ack;

    int     errors   = 0;                   // wrong values and protocol breaks
    int     timeouts = 0;
    integer seed     = 32'he84e_6fc2;

    // reference tables with each counter held as 0..3 where 2 and up means taken
    int                     m_cnt    [`BP_ENTRIES];
    bit                     m_valid  [`BP_ENTRIES];
    logic [`BP_TAG_BITS-1:0] m_tag   [`BP_ENTRIES];
    logic [`BP_PC_BITS-1:0] m_target [`BP_ENTRIES];
    int                     model_rev = 0;  // bumped on every model change
    bp_pred_t               exp_pred;

    // small pool where pairs share an index but differ in tag
    logic [`BP_PC_BITS-1:0] pc_pool [8] = '{
        32'h0000_0040, 32'h0000_2040, 32'h0000_0044, 32'hffff_e044,
        32'h0000_1ffc, 32'h8000_1ffc, 32'h0000_0000, 32'h0001_0000
    };

    tb_clock_gen u_tb_clock_gen (
        .CLK  (CLK),
        .nRST (nRST)
    );

    branch_predictor u_branch_predictor (
        .CLK      (CLK),
        .nRST     (nRST),
        .fetch_pc (fetch_pc),
        .pred     (pred),
        .upd_req  (upd_req),
        .upd      (upd),
        .upd_ack  (upd_ack)
    );

    function automatic int index_of(input logic [`BP_PC_BITS-1:0] pc);
        return int'(pc >> `BP_INDEX_LSB) % `BP_ENTRIES;     // pc bits 12:2
    endfunction

    function automatic logic [`BP_TAG_BITS-1:0] tag_of(input logic [`BP_PC_BITS-1:0] pc);
        return pc[`BP_PC_BITS-1 -: `BP_TAG_BITS];             // everything above the index
    endfunction

    function automatic bp_pred_t predict_from_model(input logic [`BP_PC_BITS-1:0] pc);
        bp_pred_t p;
        int       idx;
        idx      = index_of(pc);
        p.taken  = (m_cnt[idx] >= 2) && m_valid[idx] && (m_tag[idx] == tag_of(pc));
        p.target = p.taken ? m_target[idx] : '0;
        return p;
    endfunction

    function automatic void apply_to_model(input bp_update_t u);
        int idx;
        idx = index_of(u.pc);
        if (u.op == BR_NONE) begin
            return;                                         // non-branch leaves the tables untouched
        end
        if (u.taken) begin
            if (m_cnt[idx] < 3) begin
                m_cnt[idx]++;
            end
            m_valid[idx]  = 1'b1;
            m_tag[idx]    = tag_of(u.pc);
            m_target[idx] = u.target;
        end else if (m_cnt[idx] > 0) begin
            m_cnt[idx]--;                                   // btb keeps its entry
        end
        model_rev++;
    endfunction

    function automatic bp_update_t make_update(input logic [31:0] pc, input br_op_e op,
                                               input logic taken, input logic [31:0] target);
        bp_update_t u;
        u.pc     = pc;
        u.op     = op;
        u.taken  = taken;
        u.target = target;
        return u;
    endfunction

    function automatic bp_update_t random_update();
        bp_update_t u;
        int         r;
        int         t;
        r        = $random(seed);
        t        = $random(seed);
        u.pc     = pc_pool[r[2:0]];
        u.op     = br_op_e'(r[4:3]);
        u.taken  = (u.op == BR_JAL) ? 1'b1 : r[5];          // jal always resolves taken
        u.target = {t[31:2], 2'b00};
        return u;
    endfunction

    // expected answer follows fetch_pc and every model change
    always @(fetch_pc, model_rev) begin
        exp_pred = predict_from_model(fetch_pc);
    end

    task automatic next_cycle();
        @(posedge CLK);
        #1;                                 // drive point clear of the edge
    endtask

    task automatic wait_for_reset();
        int n;
        n = 0;
        while (!nRST && n < RESET_TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (!nRST) begin
            timeouts++;
            $display("reset was never released after %0d cycles", RESET_TIMEOUT);
        end
    endtask

    // hold the pc two edges so one sample sees it stable
    task automatic lookup(input logic [`BP_PC_BITS-1:0] pc);
        fetch_pc = pc;
        next_cycle();
        next_cycle();
    endtask

    // four-phase update where hold keeps req high that many cycles past ack
    task automatic send_update(input bp_update_t u, input int hold);
        int n;
        upd     = u;
        upd_req = 1'b1;
        n       = 0;
        while (!upd_ack && n < HS_TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (!upd_ack) begin
            timeouts++;
            $display("update handshake timed out at %0t ns waiting for upd_ack to rise", $time);
            upd_req = 1'b0;
            return;
        end
        apply_to_model(u);                  // dut tables are written once ack is up
        repeat (hold) next_cycle();
        upd_req = 1'b0;
        n       = 0;
        while (upd_ack && n < HS_TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (upd_ack) begin
            timeouts++;
            $display("update handshake timed out at %0t ns waiting for upd_ack to fall", $time);
        end
    endtask

    // lookup result against the model
    a_pred_matches: assert property (
        @(posedge CLK) disable iff (!nRST)
        $stable(fetch_pc) |-> (pred == exp_pred)
    ) else begin
        errors++;
        $display("** Error at %0t ns: pc %h expected taken=%0b target=%h, got taken=%0b target=%h",
                 $time, $sampled(fetch_pc), $sampled(exp_pred.taken), $sampled(exp_pred.target),
                 $sampled(pred.taken), $sampled(pred.target));
    end

    a_ack_low_after_reset: assert property (
        @(posedge CLK) $rose(nRST) |-> !upd_ack
    ) else begin
        errors++;
        $display("upd_ack was high right after reset at %0t ns", $time);
    end

    // ack register rises on the second edge after req is sampled and is seen one sample later
    a_ack_timing: assert property (
        @(posedge CLK) disable iff (!nRST)
        $rose(upd_req) |-> !upd_ack [*3] ##1 upd_ack
    ) else begin
        errors++;
        $display("upd_ack did not rise two cycles after upd_req at %0t ns", $time);
    end

    a_ack_release: assert property (
        @(posedge CLK) disable iff (!nRST)
        $fell(upd_req) |-> upd_ack ##1 !upd_ack
    ) else begin
        errors++;
        $display("upd_ack did not fall one cycle after upd_req dropped at %0t ns", $time);
    end

    a_ack_hold: assert property (
        @(posedge CLK) disable iff (!nRST)
        (upd_ack && upd_req) |=> upd_ack
    ) else begin
        errors++;
        $display("upd_ack dropped while upd_req was still held at %0t ns", $time);
    end

    a_single_write: assert property (
        @(posedge CLK) disable iff (!nRST)
        upd_ack |-> !u_branch_predictor.wr_en
    ) else begin
        errors++;
        $display("second table write during a held request at %0t ns", $time);
    end

    initial begin
        bp_update_t u;
        int         r;
        fetch_pc = '0;
        upd_req  = 1'b0;
        upd      = '0;
        for (int i = 0; i < `BP_ENTRIES; i++) begin
            m_cnt[i]   = 1;                 // weak not taken
            m_valid[i] = 1'b0;
        end
        wait_for_reset();
        model_rev++;

        // cold tables make random pcs and the pool all miss
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            lookup({r[31:2], 2'b00});
        end
        for (int i = 0; i < 8; i++) begin
            lookup(pc_pool[i]);
        end

        // a double write on a held request would leave the counter taken after one not-taken
        lookup(32'h0000_0100);
        send_update(make_update(32'h0000_0100, BR_BEQ, 1'b1, 32'h0000_0800), 3);
        send_update(make_update(32'h0000_0100, BR_BEQ, 1'b0, 32'h0), 0);
        lookup(32'h0000_0100);

        // training and saturation on one pc
        lookup(32'h0000_0400);
        repeat (2) send_update(make_update(32'h0000_0400, BR_BNE, 1'b1, 32'h0000_1230), 0);
        lookup(32'h0000_0400);
        repeat (2) send_update(make_update(32'h0000_0400, BR_BNE, 1'b1, 32'h0000_1230), 0);
        send_update(make_update(32'h0000_0400, BR_BNE, 1'b0, 32'h0), 0);
        lookup(32'h0000_0400);
        send_update(make_update(32'h0000_0400, BR_BNE, 1'b0, 32'h0), 0);
        lookup(32'h0000_0400);

        // tag aliasing with target replacement and non-branch updates
        send_update(make_update(32'h0000_0400, BR_BEQ, 1'b1, 32'h0000_1230), 0);
        lookup(32'h0000_0400);
        lookup(32'h0000_2400);              // same index but other tag
        send_update(make_update(32'h0000_0400, BR_JAL, 1'b1, 32'h0000_4560), 0);
        lookup(32'h0000_0400);
        // two not-taken non-branches would pull a strong counter below taken
        repeat (2) send_update(make_update(32'h0000_0400, BR_NONE, 1'b0, 32'h0), 0);
        send_update(make_update(32'h0000_0400, BR_NONE, 1'b1, 32'hdead_0000), 0);
        lookup(32'h0000_0400);
        send_update(make_update(32'h0000_2400, BR_BEQ, 1'b1, 32'h0000_7770), 0);
        lookup(32'h0000_0400);              // evicted by the alias
        lookup(32'h0000_2400);

        // random updates over the pool
        for (int i = 0; i < RANDOM_UPDATES; i++) begin
            u = random_update();
            send_update(u, 0);
            r = $random(seed);
            lookup(pc_pool[r[2:0]]);
            lookup(pc_pool[r[5:3]]);
        end

        next_cycle();
        $display("tb_branch_predictor done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- branch_predictor.f
+incdir+include
rtl/bp_pkg.sv
rtl/pattern_history_table.sv
rtl/branch_target_buffer.sv
rtl/bp_update_ctrl.sv
rtl/branch_predictor.sv
verif/tb_clock_gen.sv
verif/tb_branch_predictor.sv

//--- Bender.yml
package:
  name: branch_predictor

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/bp_pkg.sv
      - rtl/pattern_history_table.sv
      - rtl/branch_target_buffer.sv
      - rtl/bp_update_ctrl.sv
      - rtl/branch_predictor.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_branch_predictor.sv
